/* common/ltssm_cfg.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane count, link number, phase limits and block length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LTSSM_CFG_SVH
`define LTSSM_CFG_SVH

// lanes handled by the port
`define LTSSM_NUM_LANES 4

// link number carried in TS1/TS2
`define LTSSM_LINK_NUM 8'h00

// 24 ms and 2 ms phase limits, scaled down for simulation
`define LTSSM_TIMEOUT_LONG 600
`define LTSSM_TIMEOUT_SHORT 60

// received idles needed before success
`define LTSSM_IDLE_MIN 16

// stream beats per ordered set block
`define LTSSM_OS_BEATS 4

// consecutive echoing TS1s per lane
`define LTSSM_ECHO_NEEDED 2

`endif

/* common/ltssm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types and symbol constants for configuration training
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ltssm_pkg;

  typedef logic [31:0] os_word_t;

  // kind of block handed to the streamer
  typedef enum logic [1:0] {
    OS_TS1_LINK,
    OS_TS1_LANE,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LINK_WIDTH,
    ST_LINK_ACCEPT,
    ST_LANE_SEND,
    ST_LANE_ACCEPT,
    ST_TS2_SEND,
    ST_IDLE_SEND,
    ST_WAIT_EN_LOW
  } config_state_e;

  // decoded TS from one receive lane
  typedef struct packed {
    logic       ts1_valid;
    logic       ts2_valid;
    logic [7:0] link_num;
    logic [7:0] lane_num;
  } lane_rx_t;

  // link level flags from the receive side
  typedef struct packed {
    logic lanes_formed;
    logic lane_nums_match;
    logic lane_reconfig;
    logic ts2_complete;
    logic idle_received;
    logic idle_satisfied;
  } link_status_t;

  typedef struct packed {
    os_word_t   data;
    logic [3:0] keep;
    logic       last;
    logic [3:0] user;
  } os_stream_t;

  localparam logic [7:0] SYM_PAD = 8'hF7;
  localparam logic [7:0] SYM_TS1 = 8'h1E;
  localparam logic [7:0] SYM_TS2 = 8'h2D;

  // user tags on the stream
  localparam logic [3:0] USER_LINK = 4'h1;
  localparam logic [3:0] USER_LANE = 4'h3;

endpackage

/* hw/ltssm_config/config_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// configuration controller, phase timer, idle counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ltssm_cfg.svh"

module config_fsm (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    en_i,
  input  ltssm_pkg::link_status_t status_i,
  input  logic                    link_width_ok_i,
  input  logic                    os_done_i,
  output logic                    os_start_o,
  output ltssm_pkg::os_kind_e     os_kind_o,
  output logic                    monitor_clear_o,
  output logic                    success_o,
  output logic                    error_o
);
  import ltssm_pkg::*;

  localparam int TIMER_W = $clog2(`LTSSM_TIMEOUT_LONG + 1);
  localparam int IDLE_W  = $clog2(`LTSSM_IDLE_MIN + 1);
  localparam logic [TIMER_W-1:0] LIMIT_LONG  = TIMER_W'(`LTSSM_TIMEOUT_LONG);
  localparam logic [TIMER_W-1:0] LIMIT_SHORT = TIMER_W'(`LTSSM_TIMEOUT_SHORT);
  localparam logic [IDLE_W-1:0]  IDLE_MIN    = IDLE_W'(`LTSSM_IDLE_MIN);

  config_state_e      state_r;
  logic [TIMER_W-1:0] timer_r;
  logic [TIMER_W-1:0] timer_limit;
  logic [IDLE_W-1:0]  idle_cnt_r;
  logic               start_r;
  os_kind_e           kind_r;
  logic               clear_r;
  logic               success_r;
  logic               error_r;

  // only link width detection runs on the 24 ms limit
  assign timer_limit = (state_r == ST_LINK_WIDTH) ? LIMIT_LONG : LIMIT_SHORT;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r    <= ST_IDLE;
      timer_r    <= '0;
      idle_cnt_r <= '0;
      start_r    <= 1'b0;
      kind_r     <= OS_TS1_LINK;
      clear_r    <= 1'b0;
      success_r  <= 1'b0;
      error_r    <= 1'b0;
    end else begin
      start_r <= 1'b0;
      clear_r <= 1'b0;
      timer_r <= (timer_r >= timer_limit) ? timer_limit : timer_r + 1'b1;
      case (state_r)
        ST_IDLE: begin
          if (en_i) begin
            timer_r    <= '0;
            idle_cnt_r <= '0;
            clear_r    <= 1'b1;
            start_r    <= 1'b1;
            kind_r     <= OS_TS1_LINK;
            state_r    <= ST_LINK_WIDTH;
          end
        end
        ST_LINK_WIDTH: begin
          if (os_done_i) begin
            if (link_width_ok_i) begin
              timer_r <= '0;
              state_r <= ST_LINK_ACCEPT;
            end else if (timer_r >= LIMIT_LONG) begin
              error_r <= 1'b1;
              state_r <= ST_WAIT_EN_LOW;
            end else begin
              start_r <= 1'b1;
              kind_r  <= OS_TS1_LINK;
            end
          end
        end
        ST_LINK_ACCEPT: begin
          if (status_i.lanes_formed) begin
            start_r <= 1'b1;
            kind_r  <= OS_TS1_LANE;
            state_r <= ST_LANE_SEND;
          end else if (timer_r >= LIMIT_SHORT) begin
            error_r <= 1'b1;
            state_r <= ST_WAIT_EN_LOW;
          end
        end
        ST_LANE_SEND: begin
          if (os_done_i) begin
            state_r <= ST_LANE_ACCEPT;
          end
        end
        ST_LANE_ACCEPT: begin
          // no limit here, partner decides
          if (status_i.lane_nums_match) begin
            timer_r <= '0;
            start_r <= 1'b1;
            kind_r  <= OS_TS2;
            state_r <= ST_TS2_SEND;
          end else if (status_i.lane_reconfig) begin
            start_r <= 1'b1;
            kind_r  <= OS_TS1_LANE;
            state_r <= ST_LANE_SEND;
          end
        end
        ST_TS2_SEND: begin
          if (os_done_i) begin
            if (status_i.ts2_complete) begin
              start_r <= 1'b1;
              kind_r  <= OS_IDLE;
              state_r <= ST_IDLE_SEND;
            end else if (timer_r >= LIMIT_SHORT) begin
              error_r <= 1'b1;
              state_r <= ST_WAIT_EN_LOW;
            end else begin
              start_r <= 1'b1;
              kind_r  <= OS_TS2;
            end
          end
        end
        ST_IDLE_SEND: begin
          if (os_done_i) begin
            // count before this block decides
            if (status_i.idle_satisfied && (idle_cnt_r >= IDLE_MIN)) begin
              success_r <= 1'b1;
              state_r   <= ST_WAIT_EN_LOW;
            end else begin
              if (status_i.idle_received && (idle_cnt_r < IDLE_MIN)) begin
                idle_cnt_r <= idle_cnt_r + 1'b1;
              end
              start_r <= 1'b1;
              kind_r  <= OS_IDLE;
            end
          end
        end
        ST_WAIT_EN_LOW: begin
          if (!en_i) begin
            success_r <= 1'b0;
            error_r   <= 1'b0;
            state_r   <= ST_IDLE;
          end
        end
        default: begin
          state_r <= ST_IDLE;
        end
      endcase
    end
  end

  assign os_start_o      = start_r;
  assign os_kind_o       = kind_r;
  assign monitor_clear_o = clear_r;
  assign success_o       = success_r;
  assign error_o         = error_r;

  // training ends one way only
  assert property (@(posedge clk_i) disable iff (rst_i) !(success_o && error_o))
    else $error("success and error raised together");

endmodule

/* hw/ltssm_config/lane_ts_monitor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-lane TS1 echo counters, link width check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ltssm_cfg.svh"

module lane_ts_monitor (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  ltssm_pkg::lane_rx_t [`LTSSM_NUM_LANES-1:0] lane_rx_i,
  input  logic                                       clear_i,
  output logic                                       link_width_ok_o
);
  import ltssm_pkg::*;

  localparam int CNT_W = $clog2(`LTSSM_ECHO_NEEDED + 1);
  localparam logic [CNT_W-1:0] NEEDED = CNT_W'(`LTSSM_ECHO_NEEDED);

  logic [`LTSSM_NUM_LANES-1:0] reach;
  logic                        ok_r;

  for (genvar i = 0; i < `LTSSM_NUM_LANES; i++) begin : gen_lane
    logic             echo;
    logic             other;
    logic [CNT_W-1:0] cnt_r;

    // partner echoes our link number, lane still PAD
    assign echo = lane_rx_i[i].ts1_valid && (lane_rx_i[i].link_num != SYM_PAD) &&
                  (lane_rx_i[i].lane_num == SYM_PAD);
    assign other = (lane_rx_i[i].ts1_valid || lane_rx_i[i].ts2_valid) && !echo;
    assign reach[i] = echo && (cnt_r == NEEDED - 1'b1);

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        cnt_r <= '0;
      end else if (clear_i) begin
        cnt_r <= '0;
      end else if (cnt_r != NEEDED) begin
        if (echo) begin
          cnt_r <= cnt_r + 1'b1;
        end else if (other) begin
          cnt_r <= '0;
        end
      end
    end
  end

  // sticky until the next clear, counters stick too
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ok_r <= 1'b0;
    end else if (clear_i) begin
      ok_r <= 1'b0;
    end else if (|reach) begin
      ok_r <= 1'b1;
    end
  end

  assign link_width_ok_o = ok_r;

endmodule

/* hw/ltssm_config/os_streamer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ordered set block streamer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ltssm_cfg.svh"

module os_streamer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  start_i,
  input  ltssm_pkg::os_kind_e   kind_i,
  input  logic                  os_ready_i,
  output ltssm_pkg::os_stream_t os_o,
  output logic                  os_valid_o,
  output logic                  done_o
);
  import ltssm_pkg::*;

  localparam int BEAT_W = $clog2(`LTSSM_OS_BEATS);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`LTSSM_OS_BEATS - 1);

  os_kind_e          kind_r;
  logic [BEAT_W-1:0] beat_r;
  logic              valid_r;
  logic              done_r;
  logic [7:0]        sym;
  logic [7:0]        lane_byte;

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      kind_r <= kind_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      beat_r  <= '0;
      valid_r <= 1'b0;
      done_r  <= 1'b0;
    end else begin
      done_r <= 1'b0;
      if (start_i) begin
        beat_r  <= '0;
        valid_r <= 1'b1;
      end else if (valid_r && os_ready_i) begin
        if (beat_r == LAST_BEAT) begin
          valid_r <= 1'b0;
          done_r  <= 1'b1;
        end else begin
          beat_r <= beat_r + 1'b1;
        end
      end
    end
  end

  assign sym       = (kind_r == OS_TS2) ? SYM_TS2 : SYM_TS1;
  assign lane_byte = (kind_r == OS_TS1_LINK) ? SYM_PAD : 8'h00;

  // word built from latched kind and beat, so it holds under stall
  always_comb begin
    os_o.keep = '1;
    os_o.last = (beat_r == LAST_BEAT);
    os_o.user = (kind_r == OS_TS1_LINK) ? USER_LINK : USER_LANE;
    if (kind_r == OS_IDLE) begin
      os_o.data = '0;
    end else if (beat_r == '0) begin
      os_o.data = {sym, `LTSSM_LINK_NUM, lane_byte, 8'h00};
    end else begin
      os_o.data = {4{sym}};
    end
  end

  assign os_valid_o = valid_r;
  assign done_o     = done_r;

  assert property (@(posedge clk_i) disable iff (rst_i)
    os_valid_o && !os_ready_i |=> os_valid_o && $stable(os_o))
    else $error("held beat changed under back-pressure");

  // controller waits for done before the next block
  assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> !valid_r)
    else $error("start while a block is in flight");

endmodule

/* hw/ltssm_config/ltssm_config_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// configuration substate, downstream port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ltssm_cfg.svh"

module ltssm_config_top (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         en_i,
  input  ltssm_pkg::lane_rx_t [`LTSSM_NUM_LANES-1:0]   lane_rx_i,
  input  ltssm_pkg::link_status_t                      status_i,
  input  logic                                         os_ready_i,
  output ltssm_pkg::os_stream_t                        os_o,
  output logic                                         os_valid_o,
  output logic                                         success_o,
  output logic                                         error_o
);
  import ltssm_pkg::*;

  logic     os_start;
  logic     os_done;
  os_kind_e os_kind;
  logic     monitor_clear;
  logic     link_width_ok;

  config_fsm i_config_fsm (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .status_i        (status_i),
    .link_width_ok_i (link_width_ok),
    .os_done_i       (os_done),
    .os_start_o      (os_start),
    .os_kind_o       (os_kind),
    .monitor_clear_o (monitor_clear),
    .success_o       (success_o),
    .error_o         (error_o)
  );

  lane_ts_monitor i_lane_ts_monitor (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lane_rx_i       (lane_rx_i),
    .clear_i         (monitor_clear),
    .link_width_ok_o (link_width_ok)
  );

  os_streamer i_os_streamer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (os_start),
    .kind_i     (os_kind),
    .os_ready_i (os_ready_i),
    .os_o       (os_o),
    .os_valid_o (os_valid_o),
    .done_o     (os_done)
  );

endmodule

/* testbench/tb_ltssm_config.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link partner model, stream checker and test sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ltssm_cfg.svh"

module tb_ltssm_config;
  import ltssm_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int PH_RUN     = -1;
  localparam int PH_SUCCESS = 0;
  localparam int PH_WIDTH   = 1;
  localparam int PH_ACCEPT  = 2;
  localparam int PH_TS2     = 3;

  logic                            clk_i;
  logic                            rst_i;
  logic                            en_i;
  lane_rx_t [`LTSSM_NUM_LANES-1:0] lane_rx_i;
  link_status_t                    status_i;
  logic                            os_ready_i;
  os_stream_t                      os_o;
  logic                            os_valid_o;
  logic                            success_o;
  logic                            error_o;

  integer     seed;
  int         cyc = 0;
  int         err_cnt;
  int         stall;
  int         echo_lane;
  bit         echo_req;
  bit         held_valid;
  os_stream_t held_word;
  bit         tests_loaded = 1'b0;

  // one entry per test line
  int echo_q[$];
  int formed_q[$];
  int reconf_q[$];
  int ts2_q[$];
  int idle_q[$];
  int phase_q[$];
  int stall_q[$];

  ltssm_config_top i_ltssm_config_top (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .en_i       (en_i),
    .lane_rx_i  (lane_rx_i),
    .status_i   (status_i),
    .os_ready_i (os_ready_i),
    .os_o       (os_o),
    .os_valid_o (os_valid_o),
    .success_o  (success_o),
    .error_o    (error_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // count of rising edges
  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic stop_with_error(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  function automatic int token_value(input logic [8*12-1:0] tok);
    int         v;
    logic [7:0] c;
    v = 0;
    for (int i = 11; i >= 0; i--) begin
      c = tok[8*i +: 8];
      if (c >= "0" && c <= "9") begin
        v = v * 10 + (c - "0");
      end
    end
    return v;
  endfunction

  function automatic int outcome_code(input logic [8*12-1:0] tok);
    if (tok == "success") return PH_SUCCESS;
    if (tok == "err_width") return PH_WIDTH;
    if (tok == "err_accept") return PH_ACCEPT;
    if (tok == "err_ts2") return PH_TS2;
    return -2;
  endfunction

  // block contents per kind
  function automatic os_stream_t expected_beat(input os_kind_e kind, input int beat);
    os_stream_t w;
    os_word_t   word0;
    os_word_t   fill;
    w.keep = 4'hF;
    w.last = (beat == `LTSSM_OS_BEATS - 1);
    case (kind)
      OS_TS1_LINK: begin
        w.user = USER_LINK;
        word0  = {SYM_TS1, `LTSSM_LINK_NUM, SYM_PAD, 8'h00};
        fill   = {4{SYM_TS1}};
      end
      OS_TS1_LANE: begin
        w.user = USER_LANE;
        word0  = {SYM_TS1, `LTSSM_LINK_NUM, 8'h00, 8'h00};
        fill   = {4{SYM_TS1}};
      end
      OS_TS2: begin
        w.user = USER_LANE;
        word0  = {SYM_TS2, `LTSSM_LINK_NUM, 8'h00, 8'h00};
        fill   = {4{SYM_TS2}};
      end
      default: begin
        w.user = USER_LANE;
        word0  = 32'h0;
        fill   = 32'h0;
      end
    endcase
    w.data = (beat == 0) ? word0 : fill;
    return w;
  endfunction

  function automatic bit pick_ready();
    return ($unsigned($random(seed)) % 100) >= stall;
  endfunction

  task automatic load_tests();
    int                fd;
    int                n;
    int                reconf;
    int                idle;
    int                stall_v;
    logic [8*12-1:0]   echo_tok;
    logic [8*12-1:0]   formed_tok;
    logic [8*12-1:0]   ts2_tok;
    logic [8*12-1:0]   out_tok;
    logic [8*128-1:0]  line;
    fd = $fopen("testbench/ltssm_tests.txt", "r");
    if (fd == 0) stop_with_error("cannot open the test file testbench/ltssm_tests.txt");
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", echo_tok);
      if (n == 1 && echo_tok == "#") begin
        n = $fgets(line, fd);
      end else if (n == 1) begin
        n = $fscanf(fd, "%s %d %s %d %s %d", formed_tok, reconf, ts2_tok, idle, out_tok,
                    stall_v);
        if (n != 6) stop_with_error("a test line has the wrong number of columns");
        if (outcome_code(out_tok) < 0) stop_with_error("a test line has an unknown outcome");
        echo_q.push_back((echo_tok == "none") ? -1 : token_value(echo_tok));
        formed_q.push_back(formed_tok == "yes");
        reconf_q.push_back(reconf);
        ts2_q.push_back((ts2_tok == "never") ? -1 : token_value(ts2_tok));
        idle_q.push_back(idle);
        phase_q.push_back(outcome_code(out_tok));
        stall_q.push_back(stall_v);
      end
    end
    $fclose(fd);
  endtask

  // drives ready and partner lanes until one beat is accepted
  task automatic next_beat(output os_stream_t beat);
    bit       got;
    lane_rx_t echo_ts;
    got = 1'b0;
    echo_ts.ts1_valid = 1'b1;
    echo_ts.ts2_valid = 1'b0;
    echo_ts.link_num  = `LTSSM_LINK_NUM;
    echo_ts.lane_num  = SYM_PAD;
    while (!got) begin
      @(negedge clk_i);
      lane_rx_i = '0;
      if (echo_req) begin
        lane_rx_i[echo_lane] = echo_ts;
        echo_req = 1'b0;
      end
      check_value("success_o", success_o, 1'b0);
      check_value("error_o", error_o, 1'b0);
      if (held_valid) begin
        check_value("os_valid_o", os_valid_o, 1'b1);
        check_value("os_o", os_o, held_word);
      end
      os_ready_i = pick_ready();
      held_valid = os_valid_o && !os_ready_i;
      held_word  = os_o;
      if (os_valid_o && os_ready_i) begin
        beat = os_o;
        got  = 1'b1;
      end
    end
  endtask

  task automatic check_block(input os_kind_e kind, input bit echo, output int accept_cyc);
    os_stream_t beat;
    os_stream_t exp;
    for (int b = 0; b < `LTSSM_OS_BEATS; b++) begin
      next_beat(beat);
      exp = expected_beat(kind, b);
      check_value("os_o.data", beat.data, exp.data);
      check_value("os_o.keep", beat.keep, exp.keep);
      check_value("os_o.last", beat.last, exp.last);
      check_value("os_o.user", beat.user, exp.user);
      if (b == 0 && echo) echo_req = 1'b1;
    end
    // beat accepted on the coming rising edge
    accept_cyc = cyc + 1;
  endtask

  task automatic wait_outcome(input bit exp_success);
    int n;
    n = 0;
    while (!(success_o || error_o)) begin
      @(negedge clk_i);
      lane_rx_i  = '0;
      os_ready_i = pick_ready();
      check_value("os_valid_o", os_valid_o, 1'b0);
      n++;
      if (n > `LTSSM_TIMEOUT_SHORT + 16) stop_with_error("training did not end in time");
    end
    check_value("success_o", success_o, exp_success);
    check_value("error_o", error_o, !exp_success);
    // no blocks once training has ended
    repeat (20) begin
      @(negedge clk_i);
      os_ready_i = pick_ready();
      check_value("os_valid_o", os_valid_o, 1'b0);
      check_value("success_o", success_o, exp_success);
      check_value("error_o", error_o, !exp_success);
    end
  endtask

  task automatic run_test(input int t);
    int phase;
    int blk;
    int acc;
    int en_cyc;
    int lane_acc;
    int idle_cnt;
    bit linked;
    bit ts2_done;
    phase     = PH_RUN;
    stall     = stall_q[t];
    echo_lane = t % `LTSSM_NUM_LANES;
    @(negedge clk_i);
    status_i = '0;
    status_i.lanes_formed = formed_q[t][0];
    check_value("success_o", success_o, 1'b0);
    check_value("error_o", error_o, 1'b0);
    en_i   = 1'b1;
    en_cyc = cyc + 1;
    linked = 1'b0;
    blk    = 0;
    while (!linked && phase == PH_RUN) begin
      blk++;
      check_block(OS_TS1_LINK, (echo_q[t] >= 0) && (blk > echo_q[t]), acc);
      if ((echo_q[t] >= 0) && (blk >= echo_q[t] + `LTSSM_ECHO_NEEDED)) begin
        linked = 1'b1;
      end else if (acc - en_cyc >= `LTSSM_TIMEOUT_LONG) begin
        phase = PH_WIDTH;
      end
    end
    if (phase == PH_RUN && !formed_q[t]) phase = PH_ACCEPT;
    if (phase == PH_RUN) begin
      // one resend per reconfig request
      for (int j = 1; j <= reconf_q[t] + 1; j++) begin
        check_block(OS_TS1_LANE, 1'b0, lane_acc);
        status_i.lane_reconfig   = (j <= reconf_q[t]);
        status_i.lane_nums_match = (j > reconf_q[t]);
      end
      ts2_done = 1'b0;
      blk      = 0;
      while (!ts2_done && phase == PH_RUN) begin
        blk++;
        check_block(OS_TS2, 1'b0, acc);
        status_i.ts2_complete = (ts2_q[t] >= 0) && (blk > ts2_q[t]);
        if (status_i.ts2_complete) begin
          ts2_done = 1'b1;
        end else if (acc - lane_acc - 2 >= `LTSSM_TIMEOUT_SHORT) begin
          phase = PH_TS2;
        end
      end
    end
    if (phase == PH_RUN) begin
      status_i.idle_satisfied = 1'b1;
      idle_cnt = 0;
      blk      = 0;
      while (phase == PH_RUN) begin
        blk++;
        check_block(OS_IDLE, 1'b0, acc);
        status_i.idle_received = (blk <= idle_q[t]);
        // count before this block decides
        if (idle_cnt >= `LTSSM_IDLE_MIN) begin
          phase = PH_SUCCESS;
        end else if (status_i.idle_received) begin
          idle_cnt++;
        end
      end
    end
    check_value("outcome", phase, phase_q[t]);
    wait_outcome(phase == PH_SUCCESS);
    @(negedge clk_i);
    en_i = 1'b0;
    repeat (2) @(negedge clk_i);
    check_value("success_o", success_o, 1'b0);
    check_value("error_o", error_o, 1'b0);
  endtask

  initial begin
    wait (tests_loaded);
    #((echo_q.size() * (`LTSSM_TIMEOUT_LONG + 200 * 8) + 100) * CLK_PERIOD);
    $display("timeout: the tests did not finish in the expected time");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed       = 32'h7a9c3628;
    err_cnt    = 0;
    rst_i      = 1'b1;
    en_i       = 1'b0;
    lane_rx_i  = '0;
    status_i   = '0;
    os_ready_i = 1'b0;
    echo_req   = 1'b0;
    held_valid = 1'b0;
    stall      = 0;
    echo_lane  = 0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    // quiet until en_i rises
    repeat (5) begin
      @(negedge clk_i);
      check_value("os_valid_o", os_valid_o, 1'b0);
      check_value("success_o", success_o, 1'b0);
      check_value("error_o", error_o, 1'b0);
    end
    for (int t = 0; t < echo_q.size(); t++) begin
      run_test(t);
    end
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* project.f */
+incdir+common
common/ltssm_pkg.sv
hw/ltssm_config/config_fsm.sv
hw/ltssm_config/lane_ts_monitor.sv
hw/ltssm_config/os_streamer.sv
hw/ltssm_config/ltssm_config_top.sv
testbench/tb_ltssm_config.sv

/* testbench/ltssm_tests.txt */
# echo_after lanes_formed reconfigs ts2_after idle_received outcome stall_pct
# echo_after none never echoes, ts2_after never never completes
0 yes 0 0 16 success 0
2 yes 1 3 16 success 25
1 yes 2 1 20 success 50
none yes 0 0 16 err_width 10
3 no 0 0 16 err_accept 20
0 yes 1 never 16 err_ts2 30
5 yes 0 2 18 success 40
